// File: design/apm_cbb_stage.sv
`timescale 1ns/1ps
//-----------------------------
// CBB slot
// Holds the slot's TDR, ORs its power enable into the row,
// flags double enables and picks the measurement clock
//-----------------------------
module apm_cbb_stage
        import apm_pkg::*;
(
        input  logic      tck,
        input  logic      arst_n,
        // Scan bus
        input  logic      sel,
        input  logic      capture,
        input  logic      shift,
        input  logic      update,
        input  logic      si,
        output logic      so,
        // Sensor configuration
        output apm_ctrl_t cfg,
        // Row chains
        input  logic      cbb_clk,
        input  logic      meas_clk_in,
        input  logic      pwr_en_prev,
        input  logic      pwr_err_prev,
        output logic      pwr_en_next,
        output logic      pwr_err_next,
        output logic      meas_clk_out
);

        apm_ctrl_t ctrl;
        logic      pwr_en;
        logic      pwr_clash;

        apm_cbb_tdr u_tdr (
                .tck     (tck),
                .arst_n  (arst_n),
                .sel     (sel),
                .capture (capture),
                .shift   (shift),
                .update  (update),
                .si      (si),
                .so      (so),
                .ctrl    (ctrl)
        );

        // Tuning fields straight from the update stage
        assign cfg    = ctrl;
        assign pwr_en = ctrl[PWR_EN_BIT];

        //-----------------------------
        // Power enable and error chains
        //-----------------------------
        assign pwr_en_next  = pwr_en | pwr_en_prev;
        // This slot on while some earlier slot is on too
        assign pwr_clash    = pwr_en & pwr_en_prev;
        assign pwr_err_next = pwr_clash | pwr_err_prev;

        // Enabled slot overrides anything from earlier in the row
        assign meas_clk_out = pwr_en ? cbb_clk : meas_clk_in;

endmodule

// File: design/apm_cbb_tdr.sv
`timescale 1ns/1ps
//-----------------------------
// CBB test data register
// 14-bit capture/shift/update register for one slot,
// with a one-bit bypass when the slot is not selected
//-----------------------------
module apm_cbb_tdr
        import apm_pkg::*;
(
        input  logic      tck,
        input  logic      arst_n,
        input  logic      sel,
        input  logic      capture,
        input  logic      shift,
        input  logic      update,
        input  logic      si,
        output logic      so,
        output apm_ctrl_t ctrl
);

        // Shift stage
        apm_ctrl_t shift_q;
        // Update stage, drives the sensor
        apm_ctrl_t update_q;
        // Bypass bit
        logic      bypass_q;

        //-----------------------------
        // Selected path
        //-----------------------------
        always_ff @(posedge tck or negedge arst_n) begin
                if (!arst_n) begin
                        shift_q  <= '0;
                        update_q <= '0;
                end else if (sel) begin
                        // Old word goes out for readback
                        if (capture) begin
                                shift_q <= update_q;
                        end else if (shift) begin
                                // MSB takes si, LSB leaves on so
                                shift_q <= {si, shift_q[CTRL_LEN-1:1]};
                        end
                        if (update) begin
                                update_q <= shift_q;
                        end
                end
        end

        //-----------------------------
        // Bypass path
        //-----------------------------
        always_ff @(posedge tck or negedge arst_n) begin
                if (!arst_n) begin
                        bypass_q <= 1'b0;
                end else if (!sel) begin
                        // Captures a fixed zero
                        if (capture) begin
                                bypass_q <= 1'b0;
                        end else if (shift) begin
                                bypass_q <= si;
                        end
                end
        end

        // Select is stable across a whole command
        assign so   = sel ? shift_q[0] : bypass_q;
        assign ctrl = update_q;

        // Controller never overlaps these phases
        a_shift_update_excl: assert property (@(posedge tck) disable iff (!arst_n)
                !(shift && update));

endmodule

// File: design/apm_chain_top.sv
`timescale 1ns/1ps
//-----------------------------
// APM sensor chain top
// Scan controller driving a daisy chain of CBB slots
//-----------------------------
module apm_chain_top
        import apm_pkg::*;
(
        input  logic                      tck,
        input  logic                      arst_n,
        // Host command port
        input  logic                      req,
        input  logic                      cmd_write,
        input  cbb_addr_t                 cmd_addr,
        input  apm_ctrl_t                 cmd_wdata,
        output logic                      ack,
        output apm_ctrl_t                 rdata,
        // Sensor side
        input  logic [NUM_CBB-1:0]        cbb_clk,
        input  logic                      ref_clk,
        output apm_ctrl_t [NUM_CBB-1:0]   cfg,
        output logic                      pwr_any,
        output logic                      pwr_err,
        output logic                      meas_clk
);

        // Scan bus
        logic     capture;
        logic     shift;
        logic     update;
        cbb_sel_t sel;

        // Slot k sits between index k and k+1 of each chain
        logic [NUM_CBB:0] scan_w;
        logic [NUM_CBB:0] en_w;
        logic [NUM_CBB:0] err_w;
        logic [NUM_CBB:0] clk_w;

        apm_scan_ctrl u_ctrl (
                .tck       (tck),
                .arst_n    (arst_n),
                .req       (req),
                .cmd_write (cmd_write),
                .cmd_addr  (cmd_addr),
                .cmd_wdata (cmd_wdata),
                .ack       (ack),
                .rdata     (rdata),
                .so_chain  (scan_w[NUM_CBB]),
                .capture   (capture),
                .shift     (shift),
                .update    (update),
                .sel       (sel),
                .si        (scan_w[0])
        );

        //-----------------------------
        // Chain heads and tails
        //-----------------------------
        assign en_w[0]  = 1'b0;
        assign err_w[0] = 1'b0;
        assign clk_w[0] = ref_clk;

        assign pwr_any  = en_w[NUM_CBB];
        assign pwr_err  = err_w[NUM_CBB];
        assign meas_clk = clk_w[NUM_CBB];

        for (genvar k = 0; k < NUM_CBB; k++) begin : g_stage
                apm_cbb_stage u_stage (
                        .tck          (tck),
                        .arst_n       (arst_n),
                        .sel          (sel[k]),
                        .capture      (capture),
                        .shift        (shift),
                        .update       (update),
                        .si           (scan_w[k]),
                        .so           (scan_w[k+1]),
                        .cfg          (cfg[k]),
                        .cbb_clk      (cbb_clk[k]),
                        .meas_clk_in  (clk_w[k]),
                        .pwr_en_prev  (en_w[k]),
                        .pwr_err_prev (err_w[k]),
                        .pwr_en_next  (en_w[k+1]),
                        .pwr_err_next (err_w[k+1]),
                        .meas_clk_out (clk_w[k+1])
                );
        end

endmodule

// File: design/apm_pkg.sv
//-----------------------------
// APM chain shared definitions
// Chain geometry, control word and slot types,
// scan controller state encoding
//-----------------------------
package apm_pkg;

        //-----------------------------
        // Chain geometry
        //-----------------------------
        // Sensor slots in the row
        localparam int NUM_CBB    = 4;
        // TDR width per slot
        localparam int CTRL_LEN   = 14;
        // Slot number width
        localparam int ADDR_W     = 2;
        // One TDR plus one bypass bit for every other slot
        localparam int SHIFT_LEN  = CTRL_LEN + NUM_CBB - 1;
        // Shift bit counter, must reach SHIFT_LEN
        localparam int CNT_W      = $clog2(SHIFT_LEN + 1);

        // Power enable position inside the control word
        localparam int PWR_EN_BIT = 0;

        //-----------------------------
        // Control word layout, LSB up
        //   [0]     power enable
        //   [1]     cal enable
        //   [2]     osc enable
        //   [3]     step enable
        //   [5:4]   transistor select
        //   [9:6]   mux select
        //   [13:10] vdac select
        //-----------------------------
        typedef logic [CTRL_LEN-1:0] apm_ctrl_t;

        // Slot number and one-hot slot select
        typedef logic [ADDR_W-1:0]   cbb_addr_t;
        typedef logic [NUM_CBB-1:0]  cbb_sel_t;

        // Controller phases, one command per IDLE..DONE round
        typedef enum logic [2:0] {
                IDLE,
                CAPTURE,
                SHIFT,
                UPDATE,
                DONE
        } scan_state_t;

endpackage

// File: design/apm_scan_ctrl.sv
`timescale 1ns/1ps
//-----------------------------
// APM scan controller
// Takes host commands over a four-phase req/ack handshake
// and runs capture, shift and update on the CBB chain.
// Places the write word in the addressed TDR and
// pulls the captured word back out as read data.
//-----------------------------
module apm_scan_ctrl
        import apm_pkg::*;
(
        input  logic      tck,
        input  logic      arst_n,
        // Host side
        input  logic      req,
        input  logic      cmd_write,
        input  cbb_addr_t cmd_addr,
        input  apm_ctrl_t cmd_wdata,
        output logic      ack,
        output apm_ctrl_t rdata,
        // Scan bus
        input  logic      so_chain,
        output logic      capture,
        output logic      shift,
        output logic      update,
        output cbb_sel_t  sel,
        output logic      si
);

        scan_state_t            state;
        scan_state_t            state_nxt;
        logic [CNT_W-1:0]       bit_cnt;
        logic                   last_bit;
        logic                   wr_q;
        cbb_sel_t               sel_q;
        cbb_addr_t              addr_q;
        logic [ADDR_W-1:0]      tx_pad;
        logic [ADDR_W-1:0]      rx_pad;
        logic [SHIFT_LEN-1:0]   tx_sr;
        logic [SHIFT_LEN-1:0]   rx_sr;
        logic [SHIFT_LEN-1:0]   rx_aligned;
        apm_ctrl_t              rdata_q;

        // Bypass bits of the slots behind the addressed one
        // sit between its TDR and so_chain
        assign tx_pad = ADDR_W'(NUM_CBB - 1) - cmd_addr;
        assign rx_pad = ADDR_W'(NUM_CBB - 1) - addr_q;

        assign last_bit = (bit_cnt == CNT_W'(SHIFT_LEN - 1));

        //-----------------------------
        // Phase sequencing
        //-----------------------------
        always_comb begin
                state_nxt = state;
                case (state)
                        IDLE:    if (req) state_nxt = CAPTURE;
                        CAPTURE: state_nxt = SHIFT;
                        SHIFT:   if (last_bit) state_nxt = UPDATE;
                        // Read commands idle here for one cycle
                        UPDATE:  state_nxt = DONE;
                        // Hold ack until the host lets go of req
                        DONE:    if (!req) state_nxt = IDLE;
                        default: state_nxt = IDLE;
                endcase
        end

        always_ff @(posedge tck or negedge arst_n) begin
                if (!arst_n) begin
                        state   <= IDLE;
                        bit_cnt <= '0;
                        wr_q    <= 1'b0;
                        sel_q   <= '0;
                end else begin
                        state <= state_nxt;
                        case (state)
                                IDLE: if (req) begin
                                        wr_q  <= cmd_write;
                                        sel_q <= cbb_sel_t'(1) << cmd_addr;
                                end
                                CAPTURE: bit_cnt <= '0;
                                SHIFT:   bit_cnt <= bit_cnt + CNT_W'(1);
                                // Release the slot on return to zero
                                DONE:    if (!req) sel_q <= '0;
                                default: ;
                        endcase
                end
        end

        //-----------------------------
        // Data path
        //-----------------------------
        // Write word goes out LSB first behind tx_pad zero bits,
        // so_chain bits collect MSB end first
        always_ff @(posedge tck) begin
                case (state)
                        IDLE: if (req) begin
                                addr_q <= cmd_addr;
                                tx_sr  <= SHIFT_LEN'(cmd_wdata) << tx_pad;
                        end
                        SHIFT: begin
                                tx_sr <= {1'b0, tx_sr[SHIFT_LEN-1:1]};
                                rx_sr <= {so_chain, rx_sr[SHIFT_LEN-1:1]};
                        end
                        UPDATE:  rdata_q <= rx_aligned[CTRL_LEN-1:0];
                        default: ;
                endcase
        end

        // Drop the bypass bits that came out ahead of the word
        assign rx_aligned = rx_sr >> rx_pad;

        //-----------------------------
        // Outputs
        //-----------------------------
        assign capture = (state == CAPTURE);
        assign shift   = (state == SHIFT);
        assign update  = (state == UPDATE) && wr_q;
        assign ack     = (state == DONE);
        assign sel     = sel_q;
        assign si      = tx_sr[0];
        assign rdata   = rdata_q;

        // Ack only answers a req the host still held at the raising edge
        a_ack_after_req: assert property (@(posedge tck) disable iff (!arst_n)
                $rose(ack) |-> $past(req));

        // Exactly one slot on its TDR while data moves
        a_sel_onehot: assert property (@(posedge tck) disable iff (!arst_n)
                shift |-> $onehot(sel));

endmodule

// File: dv/apm_chain_cases.txt
// op (1 write, 0 read)  slot  wdata  exp_rdata  exp_pwr_any  exp_pwr_err
// all hex, wdata on reads is ignored by the DUT
1 0 1235 0000 1 0
0 0 3fff 1235 1 0
1 2 2a54 0000 1 0
0 2 0001 2a54 1 0
1 3 3fff 0000 1 1
0 1 1111 0000 1 1
1 0 0ffe 1235 1 0
1 1 1001 0000 1 1
1 3 155a 3fff 1 0
0 3 2222 155a 1 0
1 1 0000 1001 0 0
0 0 0ab1 0ffe 0 0
1 2 2a55 2a54 1 0
1 0 3c0f 0ffe 1 1
1 1 0333 0000 1 1
1 3 0001 155a 1 1
0 2 0000 2a55 1 1
1 3 0000 0001 1 1
1 2 2a54 2a55 1 1
1 1 1ffe 0333 1 0
1 0 3ffe 3c0f 0 0
0 1 3fff 1ffe 0 0
0 3 1555 0000 0 0

// File: dv/apm_chain_tb.sv
`timescale 1ns/1ps
//-----------------------------
// APM chain testbench
// Replays host commands from the cases file over req/ack,
// checks read data, slot configuration, power flags and
// the measurement clock against a model of the slot words
//-----------------------------
module apm_chain_tb
        import apm_pkg::*;
();

        localparam string CASES_FILE      = "dv/apm_chain_cases.txt";
        // op, slot, wdata, rdata, pwr_any, pwr_err
        localparam int    FIELDS          = 6;
        localparam int    MAX_CASES       = 64;
        localparam int    CYCLES_PER_CASE = 30;
        localparam int    MARGIN          = 10;
        localparam int    SAMPLE_CYCLES   = 5;
        // Half periods of the slow clocks, in tck cycles
        localparam int    REF_HALF        = 2;
        localparam int    CBB_HALF [NUM_CBB] = '{3, 4, 5, 6};

        logic                    tck;
        logic                    arst_n;
        logic                    req;
        logic                    cmd_write;
        cbb_addr_t               cmd_addr;
        apm_ctrl_t               cmd_wdata;
        logic                    ack;
        apm_ctrl_t               rdata;
        logic [NUM_CBB-1:0]      cbb_clk;
        logic                    ref_clk;
        apm_ctrl_t [NUM_CBB-1:0] cfg;
        logic                    pwr_any;
        logic                    pwr_err;
        logic                    meas_clk;

        logic [15:0] case_mem [MAX_CASES*FIELDS];
        // Expected slot words
        apm_ctrl_t   model [NUM_CBB];

        int num_cases;
        int cycle_cnt;
        int cycle_limit;
        int err_cnt;
        int case_err;
        int check_cnt;
        int pass_cnt;
        int fail_cnt;

        apm_chain_top u_dut (
                .tck       (tck),
                .arst_n    (arst_n),
                .req       (req),
                .cmd_write (cmd_write),
                .cmd_addr  (cmd_addr),
                .cmd_wdata (cmd_wdata),
                .ack       (ack),
                .rdata     (rdata),
                .cbb_clk   (cbb_clk),
                .ref_clk   (ref_clk),
                .cfg       (cfg),
                .pwr_any   (pwr_any),
                .pwr_err   (pwr_err),
                .meas_clk  (meas_clk)
        );

        initial begin
                tck = 1'b0;
                forever #50 tck = ~tck;
        end

        // Sensor clocks, all moving on the falling edge
        initial begin : slow_clocks
                int tick;
                ref_clk = 1'b0;
                cbb_clk = '0;
                tick    = 0;
                forever begin
                        @(negedge tck);
                        tick++;
                        if (tick % REF_HALF == 0) ref_clk = ~ref_clk;
                        for (int k = 0; k < NUM_CBB; k++) begin
                                if (tick % CBB_HALF[k] == 0) cbb_clk[k] = ~cbb_clk[k];
                        end
                end
        end

        //-----------------------------
        // Checking helpers
        //-----------------------------
        task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                                   input string what);
                check_cnt++;
                if (got !== exp) begin
                        $display("MISMATCH at %0t ns: %s got %0h expected %0h",
                                 $time, what, got, exp);
                        err_cnt++;
                        case_err++;
                end
        endtask

        // All four words against the model
        task automatic check_slots();
                for (int k = 0; k < NUM_CBB; k++) begin
                        check_value(32'(cfg[k]), 32'(model[k]), $sformatf("cfg[%0d]", k));
                end
        endtask

        // Highest enabled slot wins, ref_clk with none on
        task automatic check_meas_clk();
                logic      any_on;
                cbb_addr_t top_slot;
                logic      exp_clk;
                any_on   = 1'b0;
                top_slot = '0;
                for (int k = 0; k < NUM_CBB; k++) begin
                        if (model[k][PWR_EN_BIT]) begin
                                any_on   = 1'b1;
                                top_slot = cbb_addr_t'(k);
                        end
                end
                repeat (SAMPLE_CYCLES) begin
                        @(posedge tck);
                        exp_clk = any_on ? cbb_clk[top_slot] : ref_clk;
                        check_value(32'(meas_clk), 32'(exp_clk), "meas_clk");
                end
        endtask

        // Raise req and hold until ack comes back
        task automatic issue_command(input logic wr, input cbb_addr_t addr,
                                     input apm_ctrl_t wdata);
                @(negedge tck);
                cmd_write = wr;
                cmd_addr  = addr;
                cmd_wdata = wdata;
                req       = 1'b1;
                @(negedge tck);
                while (!ack) @(negedge tck);
        endtask

        // Return to zero
        task automatic release_command();
                req = 1'b0;
                while (ack) @(negedge tck);
        endtask

        task automatic close_case(input string label);
                if (case_err == 0) begin
                        pass_cnt++;
                        $display("case %s: ok", label);
                end else begin
                        fail_cnt++;
                        $display("case %s: bad, %0d errors", label, case_err);
                end
                case_err = 0;
        endtask

        //-----------------------------
        // Main sequence
        //-----------------------------
        initial begin : main
                int        base;
                logic      wr;
                cbb_addr_t addr;
                apm_ctrl_t wdata;
                apm_ctrl_t exp_rdata;
                logic      exp_any;
                logic      exp_err;
                arst_n    = 1'b0;
                req       = 1'b0;
                cmd_write = 1'b0;
                cmd_addr  = '0;
                cmd_wdata = '0;
                err_cnt   = 0;
                case_err  = 0;
                check_cnt = 0;
                pass_cnt  = 0;
                fail_cnt  = 0;
                for (int k = 0; k < NUM_CBB; k++) model[k] = '0;

                // Unread entries keep an address pattern that is no valid op
                for (int i = 0; i < MAX_CASES*FIELDS; i++) case_mem[i] = ~16'(i);
                $readmemh(CASES_FILE, case_mem);
                num_cases = 0;
                while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] <= 16'd1) begin
                        num_cases++;
                end
                if (num_cases == 0) begin
                        $display("No test cases could be read from %s", CASES_FILE);
                        err_cnt++;
                end
                cycle_limit = num_cases * CYCLES_PER_CASE + MARGIN;

                repeat (2) @(negedge tck);
                arst_n = 1'b1;
                @(negedge tck);
                check_value(32'(ack), 32'd0, "ack after reset");
                check_value(32'(pwr_any), 32'd0, "pwr_any after reset");
                check_value(32'(pwr_err), 32'd0, "pwr_err after reset");
                check_slots();
                close_case("reset");

                for (int n = 0; n < num_cases; n++) begin
                        base      = n * FIELDS;
                        wr        = case_mem[base][0];
                        addr      = case_mem[base+1][ADDR_W-1:0];
                        wdata     = case_mem[base+2][CTRL_LEN-1:0];
                        exp_rdata = case_mem[base+3][CTRL_LEN-1:0];
                        exp_any   = case_mem[base+4][0];
                        exp_err   = case_mem[base+5][0];

                        issue_command(wr, addr, wdata);
                        // Write lands in the slot, read leaves all words alone
                        if (wr) model[addr] = wdata;
                        check_value(32'(rdata), 32'(exp_rdata), "rdata");
                        check_value(32'(pwr_any), 32'(exp_any), "pwr_any");
                        check_value(32'(pwr_err), 32'(exp_err), "pwr_err");
                        check_slots();
                        release_command();
                        check_meas_clk();
                        close_case($sformatf("%0d %s slot %0d", n, wr ? "write" : "read", addr));
                end

                $display("cases %0d, passed %0d, bad %0d, checks %0d, errors %0d",
                         pass_cnt + fail_cnt, pass_cnt, fail_cnt, check_cnt, err_cnt);
                if (err_cnt == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

        // Cycle budget for the whole run
        initial begin : watchdog
                cycle_cnt = 0;
                wait (cycle_limit > 0);
                while (cycle_cnt < cycle_limit) begin
                        @(posedge tck);
                        cycle_cnt++;
                end
                $display("Timeout: run did not finish within %0d tck cycles", cycle_limit);
                $display(">>> FAIL");
                $finish;
        end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the APM chain testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
        -f verilog.f \
        --top-module apm_chain_tb \
        -o apm_chain_sim

sim_status=0
sim_out="$(./obj_dir/apm_chain_sim 2>&1)" || sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
        echo "simulator exited with status $sim_status"
        exit 1
fi

if grep -qx '>>> PASS' <<< "$sim_out"; then
        exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verilog.f
design/apm_pkg.sv
design/apm_cbb_tdr.sv
design/apm_cbb_stage.sv
design/apm_scan_ctrl.sv
design/apm_chain_top.sv
dv/apm_chain_tb.sv
